//--- flist.f
source/mmuPkg.sv
source/walkBus.sv
source/translationBuffer.sv
source/interlockFsm.sv
source/pageWalker.sv
source/memArbiter.sv
source/mmuTop.sv
tests/mmuTb.sv

//--- Makefile
# Verilator build, run and lint for the translation interlock
VERILATOR ?= verilator
TOP ?= mmuTb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= test failed
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ns -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/mmuTb.sv
// Testbench for the address-translation interlock
// Rows are applied one at a time and each waits for its own completion
// The memory model builds its page tables from the rows and answers after 1 to 4 cycles
// Level-two tables sit at 16'h2000 plus 256 times the level-one index
// Data pages live between 16'h4000 and 16'h7fff so they never overlap a table
`timescale 1ns/1ns
`default_nettype none

module mmuTb import mmuPkg::*; ();

  // Mapping that a row asks the page tables for
  typedef enum logic [1:0] {mapTwoLevel, mapLeaf, faultLevel1, faultLevel2} mapKind;

  typedef struct packed {
    logic isData;
    memOp op;
    logic [15:0] vaddr;
    logic [15:0] wdata;
    logic trap;
    mapKind kind;
    logic [15:0] expPaddr;
  } stimRow;

  localparam int cyclesPerRow = 200;
  localparam int resetCycles = 5;
  localparam int trapWindow = 4;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic fetchValid;
  logic [15:0] fetchVaddr;
  memOp dataOp;
  logic [15:0] dataVaddr;
  logic [15:0] dataWdata;
  logic trap;
  logic memValid;
  logic [15:0] memRdata;
  logic [15:0] fetchPaddr;
  logic [15:0] dataPaddr;
  logic [15:0] dataRdata;
  logic dataDone;
  logic stall;
  logic pageFault;
  logic memRead;
  logic memWrite;
  logic [15:0] memAddr;
  logic [15:0] memWdata;

  stimRow rows[$];
  logic [15:0] memory [0:65535];
  // Every request the memory port accepted, in order
  logic [15:0] seenAddr[$];
  logic seenWrite[$];
  logic [15:0] seenWdata[$];
  // Predicted buffer contents, side 0 is fetch and side 1 is data
  logic [3:0] predValid [0:1];
  logic [5:0] predTag [0:1][0:3];
  int mismatchCount = 0;
  int failureCount = 0;

  mmuTop i_dut (
    .clk(clk), .reset(reset), .fetchValid(fetchValid), .fetchVaddr(fetchVaddr),
    .dataOp(dataOp), .dataVaddr(dataVaddr), .dataWdata(dataWdata), .trap(trap),
    .memValid(memValid), .memRdata(memRdata), .fetchPaddr(fetchPaddr),
    .dataPaddr(dataPaddr), .dataRdata(dataRdata), .dataDone(dataDone), .stall(stall),
    .pageFault(pageFault), .memRead(memRead), .memWrite(memWrite), .memAddr(memAddr),
    .memWdata(memWdata)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  function automatic logic [15:0] levelOneAddr(input logic [3:0] index1);
    return rootBase + {11'd0, index1, 1'b0};
  endfunction

  function automatic logic [15:0] levelTwoAddr(input logic [3:0] index1,
                                               input logic [3:0] index2);
    return {4'h2, index1, 3'd0, index2, 1'b0};
  endfunction

  task automatic reportMismatch(input string name, input logic [15:0] got,
                                input logic [15:0] expected);
    $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, got);
    mismatchCount++;
  endtask

  task automatic reportFailure(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    failureCount++;
  endtask

  task automatic addRow(input logic isData, input memOp op, input logic [15:0] vaddr,
                        input logic [15:0] wdata, input logic trapIn, input mapKind kind,
                        input logic [15:0] expPaddr);
    stimRow r;
    r = '{isData, op, vaddr, wdata, trapIn, kind, expPaddr};
    rows.push_back(r);
  endtask

  // Page-table entries for every row, rows on the same page agree
  task automatic buildTables();
    logic [3:0] index1;
    logic [3:0] index2;
    int n;
    for (n = 0; n < rows.size(); n++) begin
      index1 = rows[n].vaddr[15:12];
      index2 = rows[n].vaddr[11:8];
      case (rows[n].kind)
        mapTwoLevel: begin
          memory[levelOneAddr(index1)] = {8'h80, 4'h2, index1};
          memory[levelTwoAddr(index1, index2)] = {2'b11, 6'd0, rows[n].expPaddr[15:8]};
        end
        mapLeaf: memory[levelOneAddr(index1)] = {2'b11, 6'd0, rows[n].expPaddr[15:8]};
        faultLevel1: memory[levelOneAddr(index1)] = 16'h0000;
        default: begin
          memory[levelOneAddr(index1)] = {8'h80, 4'h2, index1};
          memory[levelTwoAddr(index1, index2)] = 16'h0000;
        end
      endcase
    end
  endtask

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////
  initial begin : memoryModel
    int a;
    int unsigned latency;
    logic [15:0] addr;
    logic isWrite;
    logic [15:0] wdata;
    // Latencies are drawn in this process, so its generator takes the seed
    void'($urandom(32'hbbbfef15));
    memValid = 1'b0;
    memRdata = '0;
    // Odd multiplier keeps every word distinct across the whole address space
    for (a = 0; a < 65536; a++) memory[a] = 16'(a * 32'h9e37) ^ 16'h5a5a;
    @(negedge reset);
    buildTables();
    forever begin
      @(negedge clk);
      if (memRead === 1'b1 || memWrite === 1'b1) begin
        addr = memAddr;
        isWrite = memWrite;
        wdata = memWdata;
        seenAddr.push_back(addr);
        seenWrite.push_back(isWrite);
        seenWdata.push_back(wdata);
        latency = $urandom_range(4, 1);
        repeat (latency) @(posedge clk);
        #1;
        memValid = 1'b1;
        if (isWrite) memory[addr] = wdata;
        else memRdata = memory[addr];
        @(posedge clk);
        #1;
        memValid = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // One row of stimulus
  ////////////////////////////////////////
  task automatic applyRow(input stimRow r);
    logic [7:0] vpn;
    logic side;
    logic [1:0] slot;
    logic miss;
    logic walks;
    logic faults;
    logic done;
    int cycles;
    int firstSeen;
    int k;
    logic [15:0] expAddr[$];
    logic expWrite[$];
    vpn = r.vaddr[15:8];
    side = r.isData;
    slot = vpn[1:0];
    miss = !(predValid[side][slot] && predTag[side][slot] == vpn[7:2]);
    walks = miss && !r.trap;
    faults = walks && (r.kind == faultLevel1 || r.kind == faultLevel2);
    // Table reads follow the root base and the doubled index
    if (walks) begin
      expAddr.push_back(levelOneAddr(vpn[7:4]));
      expWrite.push_back(1'b0);
      if (r.kind == mapTwoLevel || r.kind == faultLevel2) begin
        expAddr.push_back(levelTwoAddr(vpn[7:4], vpn[3:0]));
        expWrite.push_back(1'b0);
      end
    end
    if (r.isData && !faults && !(miss && r.trap)) begin
      expAddr.push_back(r.expPaddr);
      expWrite.push_back(r.op == opWrite);
    end
    firstSeen = seenAddr.size();

    @(posedge clk);
    #1;
    fetchValid = !r.isData;
    // The side that is not under test points at a different page
    fetchVaddr = r.isData ? ~r.vaddr : r.vaddr;
    dataOp = r.isData ? r.op : opNone;
    dataVaddr = r.isData ? r.vaddr : ~r.vaddr;
    dataWdata = r.wdata;
    trap = r.trap;
    @(negedge clk);
    // Stall answers a walking miss in the same cycle
    if (stall !== walks) reportMismatch("stall", 16'(stall), 16'(walks));

    if (miss && r.trap) begin
      repeat (trapWindow) begin
        if (stall !== 1'b0) reportMismatch("stall", 16'(stall), 16'd0);
        if (memRead !== 1'b0 || memWrite !== 1'b0)
          reportFailure("Memory request issued for a trapped miss");
        @(negedge clk);
      end
    end else begin
      done = 1'b0;
      cycles = 0;
      while (!done && cycles < cyclesPerRow) begin
        if (faults) done = (pageFault === 1'b1);
        else if (r.isData) done = (dataDone === 1'b1);
        else done = (stall === 1'b0);
        if (!done) begin
          cycles++;
          @(negedge clk);
        end
      end
      if (!done) begin
        reportFailure($sformatf("Row at vaddr %h did not complete in time", r.vaddr));
      end else if (!faults) begin
        if (stall !== 1'b0) reportMismatch("stall", 16'(stall), 16'd0);
        if (pageFault !== 1'b0) reportMismatch("pageFault", 16'(pageFault), 16'd0);
        if (r.isData) begin
          if (dataPaddr !== r.expPaddr) reportMismatch("dataPaddr", dataPaddr, r.expPaddr);
          if (r.op == opRead && dataRdata !== memory[r.expPaddr])
            reportMismatch("dataRdata", dataRdata, memory[r.expPaddr]);
        end else if (fetchPaddr !== r.expPaddr) begin
          reportMismatch("fetchPaddr", fetchPaddr, r.expPaddr);
        end
      end
    end

    // The core drops its request once the row is over
    @(posedge clk);
    #1;
    fetchValid = 1'b0;
    dataOp = opNone;
    trap = 1'b0;
    @(negedge clk);
    if (stall !== 1'b0) reportMismatch("stall", 16'(stall), 16'd0);
    if (memRead !== 1'b0 || memWrite !== 1'b0)
      reportFailure("Memory port still busy after the row ended");

    if (seenAddr.size() - firstSeen != expAddr.size()) begin
      reportFailure($sformatf("Memory port saw %0d requests for vaddr %h, expected %0d",
                              seenAddr.size() - firstSeen, r.vaddr, expAddr.size()));
    end else begin
      for (k = 0; k < expAddr.size(); k++) begin
        if (seenAddr[firstSeen + k] !== expAddr[k])
          reportMismatch("memAddr", seenAddr[firstSeen + k], expAddr[k]);
        if (seenWrite[firstSeen + k] !== expWrite[k])
          reportMismatch("memWrite", 16'(seenWrite[firstSeen + k]), 16'(expWrite[k]));
        if (expWrite[k] && seenWdata[firstSeen + k] !== r.wdata)
          reportMismatch("memWdata", seenWdata[firstSeen + k], r.wdata);
      end
    end

    if (walks && !faults) begin
      predValid[side][slot] = 1'b1;
      predTag[side][slot] = vpn[7:2];
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin : stimulus
    int n;
    fetchValid = 1'b0;
    fetchVaddr = '0;
    dataOp = opNone;
    dataVaddr = '0;
    dataWdata = '0;
    trap = 1'b0;
    predValid[0] = '0;
    predValid[1] = '0;

    // Data miss with replay, then hits on the same page including a write
    addRow(1'b1, opRead, 16'h3104, 16'h0000, 1'b0, mapTwoLevel, 16'h4104);
    addRow(1'b1, opRead, 16'h31f0, 16'h0000, 1'b0, mapTwoLevel, 16'h41f0);
    addRow(1'b1, opWrite, 16'h3120, 16'hbeef, 1'b0, mapTwoLevel, 16'h4120);
    addRow(1'b1, opRead, 16'h3120, 16'h0000, 1'b0, mapTwoLevel, 16'h4120);
    // Fetch miss, then a fetch hit
    addRow(1'b0, opNone, 16'h5200, 16'h0000, 1'b0, mapTwoLevel, 16'h6200);
    addRow(1'b0, opNone, 16'h5280, 16'h0000, 1'b0, mapTwoLevel, 16'h6280);
    // Level-one leaf and the two kinds of fault
    addRow(1'b1, opRead, 16'h7300, 16'h0000, 1'b0, mapLeaf, 16'h4c00);
    addRow(1'b1, opRead, 16'h8400, 16'h0000, 1'b0, faultLevel1, 16'h0000);
    addRow(1'b0, opNone, 16'h9500, 16'h0000, 1'b0, faultLevel2, 16'h0000);
    // Trapped miss, then eviction of page 31 through the shared index
    addRow(1'b1, opRead, 16'ha100, 16'h0000, 1'b1, mapTwoLevel, 16'h5100);
    addRow(1'b1, opRead, 16'ha100, 16'h0000, 1'b0, mapTwoLevel, 16'h5100);
    addRow(1'b1, opRead, 16'h3104, 16'h0000, 1'b0, mapTwoLevel, 16'h4104);
    addRow(1'b1, opWrite, 16'ha1f0, 16'h1234, 1'b0, mapTwoLevel, 16'h51f0);
    addRow(1'b0, opNone, 16'h5240, 16'h0000, 1'b0, mapTwoLevel, 16'h6240);

    repeat (resetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    if (stall !== 1'b0) reportMismatch("stall", 16'(stall), 16'd0);
    if (memRead !== 1'b0) reportMismatch("memRead", 16'(memRead), 16'd0);
    if (memWrite !== 1'b0) reportMismatch("memWrite", 16'(memWrite), 16'd0);
    if (dataDone !== 1'b0) reportMismatch("dataDone", 16'(dataDone), 16'd0);
    if (pageFault !== 1'b0) reportMismatch("pageFault", 16'(pageFault), 16'd0);

    for (n = 0; n < rows.size(); n++) applyRow(rows[n]);

    $display("Value mismatches: %0d, other failures: %0d", mismatchCount, failureCount);
    if (mismatchCount == 0 && failureCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Bounds the whole run by the row count
  initial begin : watchdog
    int limitCycles;
    #1;
    limitCycles = resetCycles + 10 + rows.size() * cyclesPerRow;
    repeat (limitCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run is stuck", limitCycles);
    $display("Value mismatches: %0d, other failures: %0d", mismatchCount, failureCount);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/mmuTop.sv
// Address-translation interlock for a small in-order core
// Fetch translations appear on fetchPaddr and never use the memory port
// Data accesses and table walks share the single memory port
// The core holds fetch and data requests while stall is high and drops them on pageFault
`timescale 1ns/1ns
`default_nettype none

module mmuTop import mmuPkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fetchValid,
  input  logic [addrWidth-1:0] fetchVaddr,
  input  memOp                 dataOp,
  input  logic [addrWidth-1:0] dataVaddr,
  input  logic [addrWidth-1:0] dataWdata,
  input  logic                 trap,
  input  logic                 memValid,
  input  logic [addrWidth-1:0] memRdata,
  output logic [addrWidth-1:0] fetchPaddr,
  output logic [addrWidth-1:0] dataPaddr,
  output logic [addrWidth-1:0] dataRdata,
  output logic                 dataDone,
  output logic                 stall,
  output logic                 pageFault,
  output logic                 memRead,
  output logic                 memWrite,
  output logic [addrWidth-1:0] memAddr,
  output logic [addrWidth-1:0] memWdata
);

  logic fetchMiss;
  logic dataMiss;
  logic fetchFill;
  logic dataFill;
  logic walkFault;
  logic [vpnWidth-1:0] fillVpn;
  logic [ppnWidth-1:0] fillPpn;
  logic selWalker;
  logic selReplay;
  logic ignoreRequest;

  walkBus bus ();

  ////////////////////////////////////////
  // Translation buffers
  ////////////////////////////////////////
  translationBuffer fetchTlb (
    .clk, .reset, .lookupValid(fetchValid), .vaddr(fetchVaddr), .fill(fetchFill),
    .fillVpn, .fillPpn, .miss(fetchMiss), .paddr(fetchPaddr)
  );

  // Data lookups only happen for a real operation
  translationBuffer dataTlb (
    .clk, .reset, .lookupValid(dataOp != opNone), .vaddr(dataVaddr), .fill(dataFill),
    .fillVpn, .fillPpn, .miss(dataMiss), .paddr(dataPaddr)
  );

  ////////////////////////////////////////
  // Interlock, walker and port arbiter
  ////////////////////////////////////////
  interlockFsm interlock (
    .clk, .reset, .fetchMiss, .dataMiss, .fetchFill, .dataFill, .walkFault, .trap,
    .stall, .selWalker, .selReplay, .ignoreRequest
  );

  // The walker runs for as long as the interlock sits in its walk state
  pageWalker walker (
    .clk, .reset, .start(selWalker), .fetchMiss, .dataMiss, .fetchVaddr, .dataVaddr,
    .bus(bus.walker), .fetchFill, .dataFill, .walkFault, .fillVpn, .fillPpn
  );

  memArbiter arbiter (
    .clk, .reset, .selWalker, .selReplay, .ignoreRequest, .dataOp, .dataPaddr, .dataWdata,
    .memValid, .memRdata, .bus(bus.arbiter), .memRead, .memWrite, .memAddr, .memWdata,
    .dataRdata, .dataDone
  );

  assign pageFault = walkFault;

endmodule

`default_nettype wire

//--- source/memArbiter.sv
// Memory port arbiter for the walker and the data side
// A data request suppressed by a miss is held and replayed after the last fill
// The replay address comes from the data buffer once it has been refilled
`timescale 1ns/1ns
`default_nettype none

module memArbiter import mmuPkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 selWalker,
  input  logic                 selReplay,
  input  logic                 ignoreRequest,
  input  memOp                 dataOp,
  input  logic [addrWidth-1:0] dataPaddr,
  input  logic [addrWidth-1:0] dataWdata,
  input  logic                 memValid,
  input  logic [addrWidth-1:0] memRdata,
  walkBus.arbiter              bus,
  output logic                 memRead,
  output logic                 memWrite,
  output logic [addrWidth-1:0] memAddr,
  output logic [addrWidth-1:0] memWdata,
  output logic [addrWidth-1:0] dataRdata,
  output logic                 dataDone
);

  memOp heldOp;
  logic [addrWidth-1:0] heldWdata;
  logic replayActive;

  ////////////////////////////////////////
  // Held request
  ////////////////////////////////////////
  // An opNone capture means there is nothing to replay after the walk
  always_ff @(posedge clk) begin
    if (reset) begin
      heldOp <= opNone;
      replayActive <= 1'b0;
    end else begin
      if (ignoreRequest) heldOp <= dataOp;
      if (selReplay && heldOp != opNone) replayActive <= 1'b1;
      else if (replayActive && memValid) replayActive <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ignoreRequest) heldWdata <= dataWdata;
  end

  // Walker first, then the replay, then a live request that nothing suppresses
  always_comb begin
    memAddr = dataPaddr;
    memWdata = dataWdata;
    memRead = 1'b0;
    memWrite = 1'b0;
    if (selWalker) begin
      memAddr = bus.addr;
      memRead = bus.read;
    end else if (replayActive) begin
      memWdata = heldWdata;
      memRead = (heldOp == opRead);
      memWrite = (heldOp == opWrite);
    end else if (!ignoreRequest) begin
      memRead = (dataOp == opRead);
      memWrite = (dataOp == opWrite);
    end
  end

  // Return path
  assign bus.rdata = memRdata;
  assign bus.valid = memValid & selWalker;
  assign dataRdata = memRdata;
  assign dataDone = memValid & ~selWalker;

endmodule

`default_nettype wire

//--- source/pageWalker.sv
// Two-level hardware page walker
// Data misses are served before fetch misses when both are present at start
// A level-one leaf maps the page directly, otherwise the level-two entry is read
// At level two only the valid bit is checked, the leaf bit is not required
`timescale 1ns/1ns
`default_nettype none

module pageWalker import mmuPkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 fetchMiss,
  input  logic                 dataMiss,
  input  logic [addrWidth-1:0] fetchVaddr,
  input  logic [addrWidth-1:0] dataVaddr,
  walkBus.walker               bus,
  output logic                 fetchFill,
  output logic                 dataFill,
  output logic                 walkFault,
  output logic [vpnWidth-1:0]  fillVpn,
  output logic [ppnWidth-1:0]  fillPpn
);

  walkState state;
  logic serveData;
  logic faulted;
  logic done;
  logic [vpnWidth-1:0] walkVpn;
  logic [ppnWidth-1:0] walkPpn;
  logic [levelWidth-1:0] index1;
  logic [levelWidth-1:0] index2;
  logic pteValid;
  logic pteLeaf;

  assign index1 = walkVpn[vpnWidth-1 -: levelWidth];
  assign index2 = walkVpn[levelWidth-1:0];
  assign pteValid = bus.rdata[pteValidBit];
  assign pteLeaf = bus.rdata[pteLeafBit];

  ////////////////////////////////////////
  // Walk control
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= walkIdle;
      serveData <= 1'b0;
      faulted <= 1'b0;
    end else begin
      case (state)
        walkIdle: if (start && (fetchMiss || dataMiss)) begin
          state <= walkLevel1;
          serveData <= dataMiss;
          faulted <= 1'b0;
        end
        walkLevel1: if (bus.valid) begin
          faulted <= !pteValid;
          state <= (pteValid && !pteLeaf) ? walkLevel2 : walkDone;
        end
        walkLevel2: if (bus.valid) begin
          faulted <= !pteValid;
          state <= walkDone;
        end
        default: state <= walkIdle;
      endcase
    end
  end

  // Page under walk and the ppn of the latest entry read
  always_ff @(posedge clk) begin
    if (state == walkIdle && start) begin
      walkVpn <= dataMiss ? dataVaddr[addrWidth-1 -: vpnWidth]
                          : fetchVaddr[addrWidth-1 -: vpnWidth];
    end
    if (bus.valid) walkPpn <= bus.rdata[ppnWidth-1:0];
  end

  ////////////////////////////////////////
  // Table reads
  ////////////////////////////////////////
  // Level two reads from the table that the level-one ppn points at
  assign bus.read = (state == walkLevel1) | (state == walkLevel2);
  assign bus.addr = (state == walkLevel2)
                    ? {walkPpn, {offsetWidth{1'b0}}} + addrWidth'({index2, 1'b0})
                    : rootBase + addrWidth'({index1, 1'b0});

  // Completion pulses last exactly the one walkDone cycle
  assign done = (state == walkDone);
  assign fetchFill = done & ~faulted & ~serveData;
  assign dataFill = done & ~faulted & serveData;
  assign walkFault = done & faulted;
  assign fillVpn = walkVpn;
  assign fillPpn = walkPpn;

  readAddrStable: assert property (@(posedge clk) disable iff (reset)
    bus.read && !bus.valid |=> bus.read && $stable(bus.addr))
    else $error("Walker read address changed before valid");

endmodule

`default_nettype wire

//--- source/interlockFsm.sv
// Interlock between the core and the page walker
// A miss without trap stalls the core in the same cycle and hands the port to the walker
// A fault always returns to ready, the core is expected to trap on pageFault
// The core must keep its fetch and data request stable while stall is high
`timescale 1ns/1ns
`default_nettype none

module interlockFsm import mmuPkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic fetchMiss,
  input  logic dataMiss,
  input  logic fetchFill,
  input  logic dataFill,
  input  logic walkFault,
  input  logic trap,
  output logic stall,
  output logic selWalker,
  output logic selReplay,
  output logic ignoreRequest
);

  interlockState state;
  interlockState nextState;

  logic anyMiss;
  logic anyFill;
  logic pendingMiss;

  // A side that is being filled this cycle no longer counts as missing
  assign anyMiss = fetchMiss | dataMiss;
  assign anyFill = fetchFill | dataFill;
  assign pendingMiss = (fetchMiss & ~fetchFill) | (dataMiss & ~dataFill);

  ////////////////////////////////////////
  // State register and next state
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stateReady;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      stateReady: begin
        // Trap wins over a miss, the core is leaving this instruction anyway
        if (anyMiss && !trap) nextState = stateWalk;
      end
      stateWalk: begin
        // A second miss on the other side keeps the walker going
        if (walkFault) nextState = stateReady;
        else if (anyFill && !pendingMiss) nextState = stateReady;
      end
      default: nextState = stateReady;
    endcase
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////
  assign stall = ((state == stateReady) & anyMiss & ~trap) | (state == stateWalk);
  assign selWalker = (state == stateWalk);
  // Replay only after the last fill, never after a fault
  assign selReplay = (state == stateWalk) & anyFill & ~pendingMiss;
  // Any miss in ready suppresses the live data request, trap or not
  assign ignoreRequest = (state == stateReady) & anyMiss;

  // Fill and fault pulses only come from a walk that this FSM started
  completionInWalk: assert property (@(posedge clk) disable iff (reset)
    (anyFill || walkFault) |-> (state == stateWalk))
    else $error("Walker completion outside the walk state");

endmodule

`default_nettype wire

//--- source/translationBuffer.sv
// Four-entry direct-mapped translation buffer
// Lookup is purely combinational, so paddr is only meaningful while miss is low
// A fill becomes visible one cycle after the fill pulse
// There is no flush, an entry is only replaced by a fill to the same index
`timescale 1ns/1ns
`default_nettype none

module translationBuffer import mmuPkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 lookupValid,
  input  logic [addrWidth-1:0] vaddr,
  input  logic                 fill,
  input  logic [vpnWidth-1:0]  fillVpn,
  input  logic [ppnWidth-1:0]  fillPpn,
  output logic                 miss,
  output logic [addrWidth-1:0] paddr
);

  // Per-entry state
  logic [tlbEntries-1:0] entryValid;
  logic [tlbTagWidth-1:0] entryTag [tlbEntries];
  logic [ppnWidth-1:0] entryPpn [tlbEntries];

  // Lookup and fill fields
  logic [tlbIndexWidth-1:0] lookupIndex;
  logic [tlbTagWidth-1:0] lookupTag;
  logic [tlbIndexWidth-1:0] fillIndex;
  logic [tlbTagWidth-1:0] fillTag;

  ////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////
  // Index is the low vpn bits just above the page offset
  assign lookupIndex = vaddr[offsetWidth +: tlbIndexWidth];
  assign lookupTag = vaddr[addrWidth-1 -: tlbTagWidth];
  assign fillIndex = fillVpn[tlbIndexWidth-1:0];
  assign fillTag = fillVpn[vpnWidth-1 -: tlbTagWidth];

  ////////////////////////////////////////
  // Entry storage
  ////////////////////////////////////////
  // Only the valid bits are cleared, so an empty buffer misses everywhere
  always_ff @(posedge clk) begin
    if (reset) begin
      entryValid <= '0;
    end else if (fill) begin
      entryValid[fillIndex] <= 1'b1;
    end
  end

  // Tag and ppn overwrite whatever sat at the index before
  always_ff @(posedge clk) begin
    if (fill) begin
      entryTag[fillIndex] <= fillTag;
      entryPpn[fillIndex] <= fillPpn;
    end
  end

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////
  // No lookup requested means no miss, whatever the address
  assign miss = lookupValid &
                (~entryValid[lookupIndex] | (entryTag[lookupIndex] != lookupTag));

  // The page offset passes straight through
  assign paddr = {entryPpn[lookupIndex], vaddr[offsetWidth-1:0]};

  // The walker must be idle while the core holds reset
  fillOutsideReset: assert property (@(posedge clk) reset |-> !fill)
    else $error("Translation buffer filled during reset");

endmodule

`default_nettype wire

//--- source/walkBus.sv
// Read-only memory path between the page walker and the arbiter
// Read is a level that stays high until valid, with addr stable meanwhile
// Valid is a one-cycle pulse and rdata is only meaningful in that cycle
`timescale 1ns/1ns
`default_nettype none

interface walkBus import mmuPkg::*; ();

  logic read;
  logic [addrWidth-1:0] addr;
  logic [addrWidth-1:0] rdata;
  logic valid;

  // Walker issues table reads
  modport walker (
    output read, addr,
    input  rdata, valid
  );

  // Arbiter forwards them to memory and returns the answer
  modport arbiter (
    input  read, addr,
    output rdata, valid
  );

endinterface

`default_nettype wire

//--- source/mmuPkg.sv
// Shared widths, page-table-entry layout and enums of the translation interlock
// Virtual and physical addresses are both 16 bits with a 256-byte page
// Page tables are two levels deep and each level is indexed by 4 vpn bits
// Table entries are 16-bit words, so an entry index is doubled into a byte address
`default_nettype none

package mmuPkg;

  ////////////////////////////////////////
  // Address geometry
  ////////////////////////////////////////
  localparam int addrWidth = 16;
  localparam int offsetWidth = 8;
  localparam int vpnWidth = 8;
  localparam int ppnWidth = 8;
  localparam int levelWidth = vpnWidth / 2;

  // Direct-mapped buffers use the low vpn bits as index and the rest as tag
  localparam int tlbEntries = 4;
  localparam int tlbIndexWidth = $clog2(tlbEntries);
  localparam int tlbTagWidth = vpnWidth - tlbIndexWidth;

  ////////////////////////////////////////
  // Page-table entry layout
  ////////////////////////////////////////
  // The ppn sits in bits 7:0, the flags in the top two bits
  localparam int pteValidBit = 15;
  localparam int pteLeafBit = 14;

  // Level-one table location in physical memory
  localparam logic [addrWidth-1:0] rootBase = 16'h1000;

  // Data-side operation presented by the core
  typedef enum logic [1:0] {opNone, opRead, opWrite} memOp;

  // Interlock only needs to know whether a walk owns the memory port
  typedef enum logic {stateReady, stateWalk} interlockState;

  typedef enum logic [1:0] {walkIdle, walkLevel1, walkLevel2, walkDone} walkState;

endpackage

`default_nettype wire
